// ==== common/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data path and address width
`define CPU_XLEN 32

// instruction tag width, a new tag marks a new instruction
`define CPU_TAG_BITS 4

`endif

// ==== common/cpu_pkg.sv ====
package cpu_pkg;

	// alu functions, compares give a 1 or 0 word
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_eq,
		alu_ne,
		alu_lt,
		alu_ge,
		alu_ltu,
		alu_geu
	} alu_op_t;

	// numbered as funct3 of the M extension
	typedef enum logic [2:0] {
		md_mul    = 3'd0,
		md_mulh   = 3'd1,
		md_mulhsu = 3'd2,
		md_mulhu  = 3'd3,
		md_div    = 3'd4,
		md_divu   = 3'd5,
		md_rem    = 3'd6,
		md_remu   = 3'd7
	} muldiv_op_t;

	// access size in bytes
	typedef enum logic [2:0] {
		mem_none = 3'd0,
		mem_byte = 3'd1,
		mem_half = 3'd2,
		mem_word = 3'd4
	} mem_width_t;

	typedef enum logic [6:0] {
		opc_op     = 7'b0110011,
		opc_op_imm = 7'b0010011,
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011
	} opcode_t;

endpackage

// ==== rtl/cpu_alu.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_alu (
	input  cpu_pkg::alu_op_t      i_op,
	input  logic [`CPU_XLEN-1:0]  i_op1,
	input  logic [`CPU_XLEN-1:0]  i_op2,
	output logic [`CPU_XLEN-1:0]  o_result
);
	localparam int xlen = `CPU_XLEN;
	localparam int shift_bits = $clog2(xlen);

	logic [shift_bits-1:0] shamt;

	assign shamt = i_op2[shift_bits-1:0];

	always_comb begin
		// compares only set bit 0
		o_result = '0;
		case (i_op)
			cpu_pkg::alu_add:
				o_result = i_op1 + i_op2;
			cpu_pkg::alu_sub:
				o_result = i_op1 - i_op2;
			cpu_pkg::alu_sll:
				o_result = i_op1 << shamt;
			cpu_pkg::alu_slt:
				o_result[0] = $signed(i_op1) < $signed(i_op2);
			cpu_pkg::alu_sltu:
				o_result[0] = i_op1 < i_op2;
			cpu_pkg::alu_xor:
				o_result = i_op1 ^ i_op2;
			cpu_pkg::alu_srl:
				o_result = i_op1 >> shamt;
			cpu_pkg::alu_sra:
				o_result = $unsigned($signed(i_op1) >>> shamt);
			cpu_pkg::alu_or:
				o_result = i_op1 | i_op2;
			cpu_pkg::alu_and:
				o_result = i_op1 & i_op2;

			////////////////////////////////////////////////////////////
			// branch conditions
			////////////////////////////////////////////////////////////
			cpu_pkg::alu_eq:
				o_result[0] = i_op1 == i_op2;
			cpu_pkg::alu_ne:
				o_result[0] = i_op1 != i_op2;
			cpu_pkg::alu_lt:
				o_result[0] = $signed(i_op1) < $signed(i_op2);
			cpu_pkg::alu_ge:
				o_result[0] = $signed(i_op1) >= $signed(i_op2);
			cpu_pkg::alu_ltu:
				o_result[0] = i_op1 < i_op2;
			cpu_pkg::alu_geu:
				o_result[0] = i_op1 >= i_op2;
			default:
				o_result = '0;
		endcase
	end

endmodule

// ==== muldiv/cpu_muldiv.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_muldiv (
	input  logic                  i_clock,
	input  logic                  i_reset,
	input  logic                  i_start,
	input  cpu_pkg::muldiv_op_t   i_op,
	input  logic [`CPU_XLEN-1:0]  i_op1,
	input  logic [`CPU_XLEN-1:0]  i_op2,
	output logic                  o_busy,
	output logic                  o_done,
	output logic [`CPU_XLEN-1:0]  o_result
);
	localparam int xlen = `CPU_XLEN;

	cpu_pkg::muldiv_op_t op_q;
	logic [2*xlen-1:0] acc;
	logic [xlen-1:0] mag_b;
	logic [xlen-1:0] dividend;
	logic neg_a;
	logic neg_b;
	logic div_zero;
	logic overflow;
	logic [$clog2(xlen):0] count;

	logic a_signed;
	logic b_signed;
	logic in_neg_a;
	logic in_neg_b;
	logic [xlen-1:0] in_mag_a;
	logic [xlen-1:0] in_mag_b;

	logic is_div;
	logic [xlen:0] add_sum;
	logic [xlen+1:0] sub_diff;
	logic [2*xlen-1:0] acc_next;

	logic [2*xlen-1:0] product;
	logic [xlen-1:0] quotient;
	logic [xlen-1:0] remainder;
	logic [xlen-1:0] final_result;

	// magnitudes of the operands
	always_comb begin
		a_signed = i_op inside {cpu_pkg::md_mulh, cpu_pkg::md_mulhsu,
			cpu_pkg::md_div, cpu_pkg::md_rem};
		b_signed = i_op inside {cpu_pkg::md_mulh, cpu_pkg::md_div, cpu_pkg::md_rem};
		in_neg_a = a_signed & i_op1[xlen-1];
		in_neg_b = b_signed & i_op2[xlen-1];
		in_mag_a = in_neg_a ? -i_op1 : i_op1;
		in_mag_b = in_neg_b ? -i_op2 : i_op2;
	end

	////////////////////////////////////////////////////////////
	// one iteration
	////////////////////////////////////////////////////////////
	// funct3[2] marks a divide
	assign is_div = op_q[2];

	always_comb begin
		// multiply: add into the upper half, shift right
		add_sum = {1'b0, acc[2*xlen-1:xlen]} + (acc[0] ? {1'b0, mag_b} : '0);
		// divide: shift left, keep the trial subtract if no borrow
		sub_diff = {1'b0, acc[2*xlen-1:xlen-1]} - {2'b0, mag_b};
		if (!is_div)
			acc_next = {add_sum, acc[xlen-1:1]};
		else if (!sub_diff[xlen+1])
			acc_next = {sub_diff[xlen-1:0], acc[xlen-2:0], 1'b1};
		else
			acc_next = {acc[2*xlen-2:0], 1'b0};
	end

	// sign fix-up and RISC-V corner cases
	always_comb begin
		product = (neg_a ^ neg_b) ? -acc : acc;
		quotient = (neg_a ^ neg_b) ? -acc[xlen-1:0] : acc[xlen-1:0];
		remainder = neg_a ? -acc[2*xlen-1:xlen] : acc[2*xlen-1:xlen];
		if (div_zero) begin
			quotient = '1;
			remainder = dividend;
		end
		else if (overflow) begin
			quotient = dividend;
			remainder = '0;
		end
		case (op_q)
			cpu_pkg::md_mul:
				final_result = product[xlen-1:0];
			cpu_pkg::md_mulh, cpu_pkg::md_mulhsu, cpu_pkg::md_mulhu:
				final_result = product[2*xlen-1:xlen];
			cpu_pkg::md_div, cpu_pkg::md_divu:
				final_result = quotient;
			default:
				final_result = remainder;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_busy <= 1'b0;
			o_done <= 1'b0;
			count <= '0;
		end
		else begin
			o_done <= 1'b0;
			if (i_start && !o_busy) begin
				o_busy <= 1'b1;
				count <= '0;
			end
			else if (o_busy) begin
				if (count == xlen) begin
					o_busy <= 1'b0;
					o_done <= 1'b1;
				end
				else
					count <= count + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_start && !o_busy) begin
			op_q <= i_op;
			acc <= {{xlen{1'b0}}, in_mag_a};
			mag_b <= in_mag_b;
			dividend <= i_op1;
			neg_a <= in_neg_a;
			neg_b <= in_neg_b;
			div_zero <= i_op2 == '0;
			overflow <= b_signed && i_op1 == {1'b1, {(xlen-1){1'b0}}} && i_op2 == '1;
		end
		else if (o_busy) begin
			if (count == xlen)
				o_result <= final_result;
			else
				acc <= acc_next;
		end
	end

endmodule

// ==== rtl/cpu_execute.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_execute (
	input  logic                      i_clock,
	input  logic                      i_reset,
	input  logic                      i_stall,
	input  logic [`CPU_TAG_BITS-1:0]  i_tag,
	input  logic [`CPU_XLEN-1:0]      i_pc,
	input  logic [`CPU_XLEN-1:0]      i_instruction,
	input  logic [`CPU_XLEN-1:0]      i_rs1,
	input  logic [`CPU_XLEN-1:0]      i_rs2,
	input  logic [4:0]                i_inst_rd,
	input  logic [`CPU_XLEN-1:0]      i_imm,
	output logic [`CPU_TAG_BITS-1:0]  o_tag,
	output logic [4:0]                o_inst_rd,
	output logic [`CPU_XLEN-1:0]      o_rd,
	output logic [`CPU_XLEN-1:0]      o_pc_next,
	output logic                      o_mem_read,
	output logic                      o_mem_write,
	output cpu_pkg::mem_width_t       o_mem_width,
	output logic                      o_mem_signed,
	output logic [`CPU_XLEN-1:0]      o_mem_address,
	output logic                      o_stall
);
	localparam int xlen = `CPU_XLEN;

	cpu_pkg::opcode_t opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic is_m;

	cpu_pkg::alu_op_t alu_op;
	logic [xlen-1:0] alu_op1;
	logic [xlen-1:0] alu_op2;
	logic [xlen-1:0] alu_result;

	logic [xlen-1:0] pc_plus4;
	logic [xlen-1:0] pc_imm;

	logic accept;
	logic md_start;
	logic md_busy;
	logic md_done;
	logic [xlen-1:0] md_result;
	logic md_pending;
	logic md_held;
	logic [xlen-1:0] held_result;
	logic md_retire;

	function automatic cpu_pkg::alu_op_t arith_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: arith_op = alt ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
			3'b001: arith_op = cpu_pkg::alu_sll;
			3'b010: arith_op = cpu_pkg::alu_slt;
			3'b011: arith_op = cpu_pkg::alu_sltu;
			3'b100: arith_op = cpu_pkg::alu_xor;
			3'b101: arith_op = alt ? cpu_pkg::alu_sra : cpu_pkg::alu_srl;
			3'b110: arith_op = cpu_pkg::alu_or;
			default: arith_op = cpu_pkg::alu_and;
		endcase
	endfunction

	function automatic cpu_pkg::alu_op_t branch_op(input logic [2:0] f3);
		case (f3)
			3'b001: branch_op = cpu_pkg::alu_ne;
			3'b100: branch_op = cpu_pkg::alu_lt;
			3'b101: branch_op = cpu_pkg::alu_ge;
			3'b110: branch_op = cpu_pkg::alu_ltu;
			3'b111: branch_op = cpu_pkg::alu_geu;
			default: branch_op = cpu_pkg::alu_eq;
		endcase
	endfunction

	function automatic cpu_pkg::mem_width_t width_of(input logic [1:0] size);
		case (size)
			2'b00: width_of = cpu_pkg::mem_byte;
			2'b01: width_of = cpu_pkg::mem_half;
			default: width_of = cpu_pkg::mem_word;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// decode
	////////////////////////////////////////////////////////////
	assign opcode = cpu_pkg::opcode_t'(i_instruction[6:0]);
	assign funct3 = i_instruction[14:12];
	assign funct7 = i_instruction[31:25];
	assign is_m = opcode == cpu_pkg::opc_op && funct7 == 7'b0000001;

	assign pc_plus4 = i_pc + xlen'(4);
	assign pc_imm = i_pc + i_imm;

	always_comb begin
		alu_op = cpu_pkg::alu_add;
		alu_op1 = i_rs1;
		alu_op2 = i_imm;
		case (opcode)
			cpu_pkg::opc_op: begin
				alu_op2 = i_rs2;
				alu_op = arith_op(funct3, funct7[5]);
			end
			// only srai carries the alternate bit in the immediate
			cpu_pkg::opc_op_imm:
				alu_op = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
			cpu_pkg::opc_branch: begin
				alu_op2 = i_rs2;
				alu_op = branch_op(funct3);
			end
			cpu_pkg::opc_auipc:
				alu_op1 = i_pc;
			default:
				alu_op = cpu_pkg::alu_add;
		endcase
	end

	cpu_alu alu0 (
		.i_op(alu_op),
		.i_op1(alu_op1),
		.i_op2(alu_op2),
		.o_result(alu_result)
	);

	// a pending M op blocks new work until it retires
	assign accept = !i_stall && i_tag != o_tag && !md_pending && !md_busy;
	assign md_start = accept && is_m;

	cpu_muldiv muldiv0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_start(md_start),
		.i_op(cpu_pkg::muldiv_op_t'(funct3)),
		.i_op1(i_rs1),
		.i_op2(i_rs2),
		.o_busy(md_busy),
		.o_done(md_done),
		.o_result(md_result)
	);

	assign md_retire = !i_stall && md_pending && (md_done || md_held);
	assign o_stall = md_pending;

	////////////////////////////////////////////////////////////
	// retirement
	////////////////////////////////////////////////////////////
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_tag <= '0;
			o_inst_rd <= '0;
			o_pc_next <= '0;
			o_mem_read <= 1'b0;
			o_mem_write <= 1'b0;
			o_mem_width <= cpu_pkg::mem_none;
			o_mem_signed <= 1'b0;
			md_pending <= 1'b0;
			md_held <= 1'b0;
		end
		else if (accept && is_m)
			md_pending <= 1'b1;
		else if (accept || md_retire) begin
			o_tag <= i_tag;
			o_inst_rd <= i_inst_rd;
			o_pc_next <= pc_plus4;
			o_mem_read <= 1'b0;
			o_mem_write <= 1'b0;
			o_mem_width <= cpu_pkg::mem_none;
			o_mem_signed <= 1'b0;
			if (md_retire) begin
				o_rd <= md_held ? held_result : md_result;
				md_pending <= 1'b0;
				md_held <= 1'b0;
			end
			else begin
				case (opcode)
					cpu_pkg::opc_op, cpu_pkg::opc_op_imm, cpu_pkg::opc_auipc:
						o_rd <= alu_result;
					cpu_pkg::opc_lui:
						o_rd <= i_imm;
					cpu_pkg::opc_jal: begin
						o_rd <= pc_plus4;
						o_pc_next <= pc_imm;
					end
					cpu_pkg::opc_jalr: begin
						o_rd <= pc_plus4;
						o_pc_next <= {alu_result[xlen-1:1], 1'b0};
					end
					cpu_pkg::opc_branch:
						if (alu_result[0])
							o_pc_next <= pc_imm;
					cpu_pkg::opc_load: begin
						o_mem_address <= alu_result;
						o_mem_read <= 1'b1;
						o_mem_width <= width_of(funct3[1:0]);
						// lw, lbu and lhu are unsigned
						o_mem_signed <= !funct3[2] && funct3[1:0] != 2'b10;
					end
					cpu_pkg::opc_store: begin
						o_mem_address <= alu_result;
						o_mem_write <= 1'b1;
						o_mem_width <= width_of(funct3[1:0]);
						o_rd <= i_rs2;
					end
					default: ;
				endcase
			end
		end
		// downstream stalled when the result came back
		else if (md_done) begin
			md_held <= 1'b1;
			held_result <= md_result;
		end
	end

endmodule

// ==== tests/execute_model.svh ====
`ifndef EXECUTE_MODEL_SVH
`define EXECUTE_MODEL_SVH

// RV32I register and immediate arithmetic, alt selects sub and sra
function automatic logic [31:0] arith_value(input logic [2:0] f3, input logic alt,
	input logic [31:0] a, input logic [31:0] b);
	logic signed [31:0] sa;
	logic signed [31:0] sb;
	logic [4:0] sh;
	sa = a;
	sb = b;
	sh = b[4:0];
	case (f3)
		3'd0: return alt ? a - b : a + b;
		3'd1: return a << sh;
		3'd2: return {31'b0, sa < sb};
		3'd3: return {31'b0, a < b};
		3'd4: return a ^ b;
		3'd5: begin
			if (alt)
				return sa >>> sh;
			return a >> sh;
		end
		3'd6: return a | b;
		default: return a & b;
	endcase
endfunction

// beq bne blt bge bltu bgeu by funct3
function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
	input logic [31:0] b);
	logic signed [31:0] sa;
	logic signed [31:0] sb;
	sa = a;
	sb = b;
	case (f3)
		3'd1: return a != b;
		3'd4: return sa < sb;
		3'd5: return sa >= sb;
		3'd6: return a < b;
		3'd7: return a >= b;
		default: return a == b;
	endcase
endfunction

// M extension, 64-bit products from sign or zero extended operands
function automatic logic [31:0] muldiv_value(input logic [2:0] f3, input logic [31:0] a,
	input logic [31:0] b);
	logic [63:0] p;
	logic signed [31:0] sa;
	logic signed [31:0] sb;
	logic overflow;
	sa = a;
	sb = b;
	overflow = a == 32'h8000_0000 && b == 32'hffff_ffff;
	case (f3)
		3'd0: begin
			p = {32'b0, a} * {32'b0, b};
			return p[31:0];
		end
		3'd1: begin
			p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
			return p[63:32];
		end
		3'd2: begin
			p = {{32{a[31]}}, a} * {32'b0, b};
			return p[63:32];
		end
		3'd3: begin
			p = {32'b0, a} * {32'b0, b};
			return p[63:32];
		end
		3'd4: begin
			if (b == 32'd0)
				return '1;
			if (overflow)
				return a;
			return sa / sb;
		end
		3'd5: begin
			if (b == 32'd0)
				return '1;
			return a / b;
		end
		3'd6: begin
			if (b == 32'd0)
				return a;
			if (overflow)
				return '0;
			return sa % sb;
		end
		default: begin
			if (b == 32'd0)
				return a;
			return a % b;
		end
	endcase
endfunction

function automatic cpu_pkg::mem_width_t access_width(input logic [1:0] size);
	case (size)
		2'd0: return cpu_pkg::mem_byte;
		2'd1: return cpu_pkg::mem_half;
		default: return cpu_pkg::mem_word;
	endcase
endfunction

// expected outputs of one retired instruction
task automatic predict(input logic [31:0] instr, pc, a, b, imm,
	output logic rd_valid, output logic [31:0] rd, pc_next, address,
	output logic mem_read, mem_write, mem_signed, output cpu_pkg::mem_width_t width);
	cpu_pkg::opcode_t opc;
	logic [2:0] f3;
	logic [6:0] f7;
	opc = cpu_pkg::opcode_t'(instr[6:0]);
	f3 = instr[14:12];
	f7 = instr[31:25];
	rd_valid = 1'b1;
	rd = '0;
	pc_next = pc + 32'd4;
	address = a + imm;
	mem_read = 1'b0;
	mem_write = 1'b0;
	mem_signed = 1'b0;
	width = cpu_pkg::mem_none;
	case (opc)
		cpu_pkg::opc_op: begin
			if (f7 == 7'h01)
				rd = muldiv_value(f3, a, b);
			else
				rd = arith_value(f3, f7[5], a, b);
		end
		cpu_pkg::opc_op_imm:
			rd = arith_value(f3, f3 == 3'd5 && f7[5], a, imm);
		cpu_pkg::opc_lui:
			rd = imm;
		cpu_pkg::opc_auipc:
			rd = pc + imm;
		cpu_pkg::opc_jal: begin
			rd = pc + 32'd4;
			pc_next = pc + imm;
		end
		cpu_pkg::opc_jalr: begin
			rd = pc + 32'd4;
			pc_next = (a + imm) & ~32'd1;
		end
		cpu_pkg::opc_branch: begin
			rd_valid = 1'b0;
			if (branch_taken(f3, a, b))
				pc_next = pc + imm;
		end
		cpu_pkg::opc_load: begin
			rd_valid = 1'b0;
			mem_read = 1'b1;
			width = access_width(f3[1:0]);
			// lw has no extension to do, only lb and lh are flagged
			mem_signed = f3 == 3'd0 || f3 == 3'd1;
		end
		cpu_pkg::opc_store: begin
			rd = b;
			mem_write = 1'b1;
			width = access_width(f3[1:0]);
		end
		default:
			rd_valid = 1'b0;
	endcase
endtask

`endif

// ==== tests/cpu_execute_tb.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_execute_tb;
	logic i_clock;
	logic i_reset;
	logic i_stall;
	logic [`CPU_TAG_BITS-1:0] i_tag;
	logic [`CPU_XLEN-1:0] i_pc;
	logic [`CPU_XLEN-1:0] i_instruction;
	logic [`CPU_XLEN-1:0] i_rs1;
	logic [`CPU_XLEN-1:0] i_rs2;
	logic [4:0] i_inst_rd;
	logic [`CPU_XLEN-1:0] i_imm;
	logic [`CPU_TAG_BITS-1:0] o_tag;
	logic [4:0] o_inst_rd;
	logic [`CPU_XLEN-1:0] o_rd;
	logic [`CPU_XLEN-1:0] o_pc_next;
	logic o_mem_read;
	logic o_mem_write;
	cpu_pkg::mem_width_t o_mem_width;
	logic o_mem_signed;
	logic [`CPU_XLEN-1:0] o_mem_address;
	logic o_stall;

	integer seed;
	int checks = 0;
	int value_errors = 0;
	int timeouts = 0;
	int other_errors = 0;
	logic [2:0] load_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
	logic [2:0] branch_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

	// last retirement as the model predicts it
	logic [`CPU_TAG_BITS-1:0] done_tag;
	logic [`CPU_XLEN-1:0] done_rd;
	logic done_rd_known;

	`include "execute_model.svh"

	cpu_execute dut0 (.*);

	always #20 i_clock = ~i_clock;

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////
	task automatic check_word(input string name, input logic [`CPU_XLEN-1:0] expected, actual);
		checks++;
		if (actual !== expected) begin
			value_errors++;
			$display("Error %s expected %h got %h", name, expected, actual);
		end
	endtask

	task automatic check_width(input string name, input cpu_pkg::mem_width_t expected, actual);
		checks++;
		if (actual !== expected) begin
			value_errors++;
			$display("Error %s expected %h got %h", name, expected, actual);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, actual);
		checks++;
		if (actual !== expected) begin
			value_errors++;
			$display("Error %s expected %h got %h", name, expected, actual);
		end
	endtask

	// tag is zero extended to the width of a register index
	task automatic check_tag(input string name, input logic [4:0] expected, actual);
		checks++;
		if (actual !== expected) begin
			value_errors++;
			$display("Error %s expected %h got %h", name, expected, actual);
		end
	endtask

	////////////////////////////////////////////////////////////
	// stimulus and waits
	////////////////////////////////////////////////////////////
	// outputs must not move while downstream stalls
	task automatic hold_stall(input int cycles);
		i_stall = 1'b1;
		repeat (cycles) begin
			@(posedge i_clock);
			#2;
			check_tag("o_tag", {1'b0, done_tag}, {1'b0, o_tag});
			if (done_rd_known)
				check_word("o_rd", done_rd, o_rd);
		end
		i_stall = 1'b0;
	endtask

	task automatic wait_done(input int mid_stall, output logic saw_stall, output logic finished);
		int cycles;
		cycles = 0;
		saw_stall = 1'b0;
		while (o_tag != i_tag && cycles < 100) begin
			@(posedge i_clock);
			#2;
			cycles++;
			if (o_stall)
				saw_stall = 1'b1;
			// a stall late in a divide tends to cover the done pulse
			if (cycles == 31 && mid_stall > 0 && o_tag != i_tag)
				hold_stall(mid_stall);
		end
		finished = o_tag == i_tag;
	endtask

	task automatic random_instruction(output logic [31:0] instr, a, b, imm);
		int cls;
		logic [31:0] r;
		cpu_pkg::opcode_t opc;
		logic [2:0] f3;
		logic [6:0] f7;
		cls = $unsigned($random(seed)) % 10;
		r = $random(seed);
		a = $random(seed);
		b = $random(seed);
		f3 = r[14:12];
		f7 = r[31:25];
		imm = {{20{r[31]}}, r[31:20]};
		case (cls)
			0: begin
				opc = cpu_pkg::opc_op;
				f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[30]) ? 7'h20 : 7'h00;
			end
			1: begin
				opc = cpu_pkg::opc_op_imm;
				if (f3 == 3'd1 || f3 == 3'd5) begin
					f7 = (f3 == 3'd5 && r[30]) ? 7'h20 : 7'h00;
					imm = {20'b0, f7, r[24:20]};
				end
			end
			2: begin
				opc = cpu_pkg::opc_lui;
				imm = {r[31:12], 12'b0};
			end
			3: begin
				opc = cpu_pkg::opc_auipc;
				imm = {r[31:12], 12'b0};
			end
			4: begin
				opc = cpu_pkg::opc_jal;
				imm = {{11{r[31]}}, r[31], r[19:12], r[20], r[30:21], 1'b0};
			end
			5: begin
				opc = cpu_pkg::opc_jalr;
				f3 = 3'd0;
			end
			6: begin
				opc = cpu_pkg::opc_branch;
				f3 = branch_f3[$unsigned($random(seed)) % 6];
				imm = {{19{r[31]}}, r[31], r[7], r[30:25], r[11:8], 1'b0};
				if (r[16])
					b = a;
			end
			7: begin
				opc = cpu_pkg::opc_load;
				f3 = load_f3[$unsigned($random(seed)) % 5];
			end
			8: begin
				opc = cpu_pkg::opc_store;
				f3 = {1'b0, r[13] ? 2'd2 : {1'b0, r[12]}};
				imm = {{20{r[31]}}, r[31:25], r[11:7]};
			end
			default: begin
				opc = cpu_pkg::opc_op;
				f7 = 7'h01;
				// small divisors including zero
				if (r[15])
					b = b & 32'hf;
			end
		endcase
		instr = {f7, r[24:15], f3, r[11:7], opc};
	endtask

	function automatic logic [31:0] m_instruction(input logic [2:0] f3);
		return {7'h01, 5'd2, 5'd1, f3, 5'd5, cpu_pkg::opc_op};
	endfunction

	task automatic execute(input logic [31:0] instr, a, b, imm, input int pre_stall,
		input int mid_stall);
		logic saw_stall;
		logic finished;
		logic rd_valid;
		logic [31:0] exp_rd;
		logic [31:0] exp_pc;
		logic [31:0] exp_addr;
		logic exp_read;
		logic exp_write;
		logic exp_signed;
		cpu_pkg::mem_width_t exp_width;
		i_instruction = instr;
		i_rs1 = a;
		i_rs2 = b;
		i_imm = imm;
		i_inst_rd = instr[11:7];
		i_pc = $random(seed) & 32'hffff_fffc;
		i_tag = i_tag + 1'b1;
		if (pre_stall > 0)
			hold_stall(pre_stall);
		wait_done(mid_stall, saw_stall, finished);
		if (!finished) begin
			timeouts++;
			$display("timeout: tag %0h did not complete within 100 cycles", i_tag);
		end
		else begin
			predict(instr, i_pc, a, b, imm, rd_valid, exp_rd, exp_pc, exp_addr,
				exp_read, exp_write, exp_signed, exp_width);
			done_tag = i_tag;
			if (rd_valid) begin
				done_rd = exp_rd;
				done_rd_known = 1'b1;
			end
			check_tag("o_inst_rd", instr[11:7], o_inst_rd);
			check_word("o_pc_next", exp_pc, o_pc_next);
			if (rd_valid)
				check_word("o_rd", exp_rd, o_rd);
			if (exp_read || exp_write)
				check_word("o_mem_address", exp_addr, o_mem_address);
			check_flag("o_mem_read", exp_read, o_mem_read);
			check_flag("o_mem_write", exp_write, o_mem_write);
			check_flag("o_mem_signed", exp_signed, o_mem_signed);
			check_width("o_mem_width", exp_width, o_mem_width);
			if (instr[6:0] == cpu_pkg::opc_op && instr[31:25] == 7'h01 && !saw_stall) begin
				other_errors++;
				$display("o_stall never went high during a multiply or divide");
			end
		end
	endtask

	initial begin
		logic [31:0] instr;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		int pre;
		int mid;
		seed = 32'h2d6a;
		done_tag = '0;
		done_rd = '0;
		done_rd_known = 1'b0;
		i_clock = 1'b0;
		i_reset = 1'b1;
		i_stall = 1'b0;
		i_tag = '0;
		i_pc = '0;
		i_instruction = '0;
		i_rs1 = '0;
		i_rs2 = '0;
		i_inst_rd = '0;
		i_imm = '0;
		repeat (4) @(posedge i_clock);
		#2;
		i_reset = 1'b0;
		check_tag("o_tag", 5'd0, {1'b0, o_tag});
		check_flag("o_mem_read", 1'b0, o_mem_read);
		check_flag("o_mem_write", 1'b0, o_mem_write);
		check_width("o_mem_width", cpu_pkg::mem_none, o_mem_width);
		check_flag("o_stall", 1'b0, o_stall);
		check_word("o_pc_next", '0, o_pc_next);

		repeat (300) begin
			random_instruction(instr, a, b, imm);
			pre = 0;
			mid = 0;
			if ($unsigned($random(seed)) % 8 == 0)
				pre = 1 + $unsigned($random(seed)) % 10;
			if (instr[31:25] == 7'h01 && instr[6:0] == cpu_pkg::opc_op
				&& $unsigned($random(seed)) % 2 == 1)
				mid = 1 + $unsigned($random(seed)) % 10;
			execute(instr, a, b, imm, pre, mid);
		end

		// division by zero, then most negative over minus one
		for (int f3 = 4; f3 < 8; f3++)
			execute(m_instruction(3'(f3)), $random(seed), 32'd0, 32'd0, 0, 0);
		for (int f3 = 4; f3 < 8; f3++)
			execute(m_instruction(3'(f3)), 32'h8000_0000, 32'hffff_ffff, 32'd0, 0, 0);

		// stall when presented, then stall while a divide runs
		random_instruction(instr, a, b, imm);
		execute(instr, a, b, imm, 1 + $unsigned($random(seed)) % 10, 0);
		execute(m_instruction(3'd4), $random(seed), $random(seed), 32'd0, 0,
			1 + $unsigned($random(seed)) % 10);

		$display("checks %0d, value errors %0d, timeouts %0d, other errors %0d",
			checks, value_errors, timeouts, other_errors);
		if (value_errors == 0 && timeouts == 0 && other_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+common
+incdir+tests
common/cpu_pkg.sv
rtl/cpu_alu.sv
muldiv/cpu_muldiv.sv
rtl/cpu_execute.sv
tests/cpu_execute_tb.sv

// ==== run.sh ====
#!/bin/bash
# build and run the execute stage testbench with Verilator, then search the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f flist.f --top-module cpu_execute_tb \
	--Mdir obj_dir -o cpu_execute_sim > build.log 2>&1 \
	&& ./obj_dir/cpu_execute_sim > sim.log 2>&1 \
	|| echo "build or simulation did not complete, see build.log and sim.log"
grep -qx ">>> PASS" sim.log && echo "execute stage test passed" && exit 0
echo "execute stage test failed"
exit 1
